// ==== Bender.yml ====
package:
  name: striped_async_fifo

sources:
  - include_dirs:
      - .
    files:
      - fifo_data_pkg.sv
      - lane_sched_pkg.sv
      - gray_sync.sv
      - async_fifo_lane.sv
      - lane_spreader.sv
      - lane_merger.sv
      - striped_async_fifo.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clk_gen.sv
      - tb_striped_fifo.sv

// ==== async_fifo_lane.sv ====
/* gray-pointer dual-clock FIFO lane with first-word-fall-through read data.
   chaos mode may raise full while space remains, only when built with FIFO_CHAOS */
`timescale 1ns/1ps
`include "fifo_config.svh"

module async_fifo_lane
   import fifo_data_pkg::*;
#(
   parameter int LANE_ID = 0   // varies the chaos LFSR seed per lane
)
(
   // write port
   input  logic       wr_clk,
   input  logic       wr_nreset,
   input  fifo_word_t wr_din,        // word to store
   input  logic       wr_en,         // write request
   input  logic       wr_chaosmode,  // allow random full
   output logic       wr_full,       // registered full
   // read port
   input  logic       rd_clk,
   input  logic       rd_nreset,
   input  logic       rd_en,         // read request
   output fifo_word_t rd_dout,       // head word, valid while not empty
   output logic       rd_empty       // registered empty
);

   // write domain pointers
   lane_ptr_t  wr_bin;
   lane_ptr_t  wr_gray;
   lane_ptr_t  wr_bin_nxt;
   lane_ptr_t  wr_gray_nxt;
   lane_ptr_t  rd_gray_sync;   // read pointer seen in wr_clk
   lane_addr_t wr_addr;
   logic       wr_accept;
   logic       wr_chaos_bit;   // lfsr output, zero when chaos not built

   // read domain pointers
   lane_ptr_t  rd_bin;
   lane_ptr_t  rd_gray;
   lane_ptr_t  rd_bin_nxt;
   lane_ptr_t  rd_gray_nxt;
   lane_ptr_t  wr_gray_sync;   // write pointer seen in rd_clk
   lane_addr_t rd_addr;

   fifo_word_t mem [`FIFO_DEPTH];   // lane storage

   //########################################
   // write side
   //########################################
   assign wr_accept   = wr_en & ~wr_full;
   assign wr_bin_nxt  = wr_bin + lane_ptr_t'(wr_accept);
   assign wr_gray_nxt = wr_bin_nxt ^ (wr_bin_nxt >> 1);   // bin to gray
   assign wr_addr     = lane_addr_t'(wr_bin);              // drop wrap bit

   always_ff @(posedge wr_clk or negedge wr_nreset)
   begin
      if (!wr_nreset)
      begin
         wr_bin  <= '0;
         wr_gray <= '0;
      end
      else
      begin
         wr_bin  <= wr_bin_nxt;
         wr_gray <= wr_gray_nxt;
      end
   end

   // full when next write pointer sits one lap ahead of read pointer
   // in gray code that is the top two bits inverted, rest equal
   always_ff @(posedge wr_clk or negedge wr_nreset)
   begin
      if (!wr_nreset)
         wr_full <= 1'b0;
      else
         wr_full <= (wr_chaos_bit & wr_chaosmode) |
                    (wr_gray_nxt == {~rd_gray_sync[LANE_AW:LANE_AW-1],
                                     rd_gray_sync[LANE_AW-2:0]});
   end

   // write pointer into read domain
   gray_sync u_wr2rd_sync
   (
      .clk    (rd_clk),
      .nreset (rd_nreset),
      .in     (wr_gray),
      .out    (wr_gray_sync)
   );

   //########################################
   // read side
   //########################################
   assign rd_bin_nxt  = rd_bin + lane_ptr_t'(rd_en & ~rd_empty);
   assign rd_gray_nxt = rd_bin_nxt ^ (rd_bin_nxt >> 1);
   assign rd_addr     = lane_addr_t'(rd_bin);

   always_ff @(posedge rd_clk or negedge rd_nreset)
   begin
      if (!rd_nreset)
      begin
         rd_bin  <= '0;
         rd_gray <= '0;
      end
      else
      begin
         rd_bin  <= rd_bin_nxt;
         rd_gray <= rd_gray_nxt;
      end
   end

   // empty once the next read pointer catches the synced write pointer
   always_ff @(posedge rd_clk or negedge rd_nreset)
   begin
      if (!rd_nreset)
         rd_empty <= 1'b1;
      else
         rd_empty <= (rd_gray_nxt == wr_gray_sync);
   end

   // read pointer into write domain
   gray_sync u_rd2wr_sync
   (
      .clk    (wr_clk),
      .nreset (wr_nreset),
      .in     (rd_gray),
      .out    (rd_gray_sync)
   );

   //########################################
   // storage
   //########################################
   always_ff @(posedge wr_clk)
   begin
      if (wr_accept)
         mem[wr_addr] <= wr_din;
   end

   assign rd_dout = mem[rd_addr];   // fall-through, no read register

   //########################################
   // chaos full generator
   //########################################
   if (`FIFO_CHAOS) begin : g_chaos
      // low byte kept nonzero so the seed is never the lock-up state
      localparam logic [15:0] LFSR_SEED = {8'(LANE_ID) ^ 8'h5A, 8'hC3};

      logic [15:0] lfsr;

      always_ff @(posedge wr_clk or negedge wr_nreset)
      begin
         if (!wr_nreset)
            lfsr <= LFSR_SEED;
         else if (lfsr[0])
            lfsr <= (lfsr >> 1) ^ `FIFO_LFSR_TAPS;   // feed back through taps
         else
            lfsr <= lfsr >> 1;
      end

      assign wr_chaos_bit = lfsr[0];
   end
   else begin : g_no_chaos
      assign wr_chaos_bit = 1'b0;   // full only from pointers
   end

endmodule

// ==== fifo_cases.txt ====
# id  mode    words  wr_gap  rd_gap
# burst words must be lanes x depth, gaps are max idle cycles per word
1  burst   16  0  0
2  stream  64  2  0
3  stream  64  0  3
4  stream  80  3  3
5  chaos   64  0  1
6  chaos   48  2  2
7  burst   16  0  0

// ==== fifo_config.svh ====
/* lanes and depth must be powers of two, with at least 2 lanes and depth at least 4.
   chaos taps set a 16-bit right-shifting Galois LFSR */
`ifndef FIFO_CONFIG_SVH
`define FIFO_CONFIG_SVH

//########################################
// datapath
//########################################
`define FIFO_DW 16           // bits per data word

//########################################
// striping geometry
//########################################
`define FIFO_LANES 4         // lane count, power of two
`define FIFO_DEPTH 4         // words per lane, power of two, >= 4

//########################################
// back-pressure test hooks
//########################################
`define FIFO_CHAOS 1         // 1 builds the random full generator per lane
// x^16 + x^14 + x^13 + x^11 + 1, maximal length
`define FIFO_LFSR_TAPS 16'hB400

`endif

// ==== fifo_data_pkg.sv ====
/* word and pointer types for one lane; pointer carries one extra wrap bit */
`include "fifo_config.svh"

package fifo_data_pkg;

   //########################################
   // payload
   //########################################
   typedef logic [`FIFO_DW-1:0] fifo_word_t;     // one data word

   //########################################
   // lane pointers
   //########################################
   // address bits inside one lane
   localparam int LANE_AW = $clog2(`FIFO_DEPTH);

   // binary or gray pointer, msb is the wrap bit
   typedef logic [LANE_AW:0] lane_ptr_t;

   // storage index, pointer without wrap bit
   typedef logic [LANE_AW-1:0] lane_addr_t;

endpackage

// ==== gray_sync.sv ====
/* two-flop pointer synchronizer, only safe when at most one bit changes per source edge */
`timescale 1ns/1ps

module gray_sync
   import fifo_data_pkg::*;
(
   input  logic      clk,      // destination clock
   input  logic      nreset,   // destination reset, async
   input  lane_ptr_t in,       // gray pointer from the source domain
   output lane_ptr_t out       // synchronized copy
);

   lane_ptr_t sync_q;          // first stage, may go metastable

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         sync_q <= '0;
         out    <= '0;
      end
      else
      begin
         sync_q <= in;       // capture
         out    <= sync_q;   // settle
      end
   end

endmodule

// ==== lane_merger.sv ====
/* collects words round-robin from the lanes in the same order the spreader dealt them */
`timescale 1ns/1ps
`include "fifo_config.svh"

module lane_merger
   import fifo_data_pkg::*, lane_sched_pkg::*;
(
   input  logic                          rd_clk,
   input  logic                          rd_nreset,
   input  logic                          rd_en,        // read request from outside
   input  lane_flags_t                   lane_empty,   // empty of every lane
   input  fifo_word_t [`FIFO_LANES-1:0]  lane_dout,    // head word of every lane
   output lane_flags_t                   lane_read,    // one-hot read enable
   output fifo_word_t                    rd_dout,      // head of current lane
   output logic                          rd_empty      // empty of current lane
);

   lane_idx_t rd_lane;     // lane holding the next word in order
   logic      rd_accept;

   //########################################
   // lane select
   //########################################
   assign rd_empty  = lane_empty[rd_lane];
   assign rd_dout   = lane_dout[rd_lane];
   assign rd_accept = rd_en & ~rd_empty;

   always_comb
   begin
      lane_read          = '0;
      lane_read[rd_lane] = rd_en;   // lane ignores it while empty
   end

   //########################################
   // round-robin pointer
   //########################################
   always_ff @(posedge rd_clk or negedge rd_nreset)
   begin
      if (!rd_nreset)
         rd_lane <= '0;
      else if (rd_accept)
      begin
         if (rd_lane == lane_idx_t'(`FIFO_LANES - 1))
            rd_lane <= '0;
         else
            rd_lane <= rd_lane + 1'b1;   // next lane in write order
      end
   end

endmodule

// ==== lane_sched_pkg.sv ====
/* lane scheduling types for the round-robin spreader and merger */
`include "fifo_config.svh"

package lane_sched_pkg;

   // index bits, needs at least two lanes
   localparam int LANE_IW = $clog2(`FIFO_LANES);

   typedef logic [LANE_IW-1:0] lane_idx_t;        // current lane number

   // one bit per lane
   // used for write enables, fulls, read enables, empties
   typedef logic [`FIFO_LANES-1:0] lane_flags_t;

endpackage

// ==== lane_spreader.sv ====
/* deals accepted writes round-robin over the lanes; a refused write keeps its lane */
`timescale 1ns/1ps
`include "fifo_config.svh"

module lane_spreader
   import lane_sched_pkg::*;
(
   input  logic        wr_clk,
   input  logic        wr_nreset,
   input  logic        wr_en,        // write request from outside
   input  lane_flags_t lane_full,    // full of every lane
   output lane_flags_t lane_write,   // one-hot write enable
   output logic        wr_full       // full of the current lane
);

   lane_idx_t wr_lane;    // lane that takes the next word
   logic      wr_accept;

   //########################################
   // lane select
   //########################################
   assign wr_full   = lane_full[wr_lane];
   assign wr_accept = wr_en & ~wr_full;

   // request goes to current lane only, lane itself gates with its full
   always_comb
   begin
      lane_write          = '0;
      lane_write[wr_lane] = wr_en;
   end

   //########################################
   // round-robin pointer
   //########################################
   always_ff @(posedge wr_clk or negedge wr_nreset)
   begin
      if (!wr_nreset)
         wr_lane <= '0;
      else if (wr_accept)
      begin
         if (wr_lane == lane_idx_t'(`FIFO_LANES - 1))
            wr_lane <= '0;              // wrap to first lane
         else
            wr_lane <= wr_lane + 1'b1;
      end
   end

endmodule

// ==== project.f ====
+incdir+.
fifo_data_pkg.sv
lane_sched_pkg.sv
gray_sync.sv
async_fifo_lane.sv
lane_spreader.sv
lane_merger.sv
striped_async_fifo.sv
tb_clk_gen.sv
tb_striped_fifo.sv

// ==== striped_async_fifo.sv ====
/* striped dual-clock FIFO, capacity FIFO_LANES x FIFO_DEPTH words.
   flags come straight from the selected lanes, no extra registers */
`timescale 1ns/1ps
`include "fifo_config.svh"

module striped_async_fifo
   import fifo_data_pkg::*, lane_sched_pkg::*;
(
   // write side
   input  logic       wr_clk,
   input  logic       wr_nreset,
   input  fifo_word_t wr_din,        // data to write
   input  logic       wr_en,         // write request
   input  logic       wr_chaosmode,  // random full on every lane
   output logic       wr_full,       // current write lane is full
   // read side
   input  logic       rd_clk,
   input  logic       rd_nreset,
   input  logic       rd_en,         // read request
   output fifo_word_t rd_dout,       // oldest word, valid while not empty
   output logic       rd_empty       // current read lane is empty
);

   lane_flags_t                  lane_write;   // spreader to lanes
   lane_flags_t                  lane_full;
   lane_flags_t                  lane_read;    // merger to lanes
   lane_flags_t                  lane_empty;
   fifo_word_t [`FIFO_LANES-1:0] lane_dout;

   //########################################
   // write distribution
   //########################################
   lane_spreader u_spreader
   (
      .wr_clk     (wr_clk),
      .wr_nreset  (wr_nreset),
      .wr_en      (wr_en),
      .lane_full  (lane_full),
      .lane_write (lane_write),
      .wr_full    (wr_full)
   );

   //########################################
   // lanes
   //########################################
   for (genvar i = 0; i < `FIFO_LANES; i++) begin : g_lane
      async_fifo_lane #(
         .LANE_ID (i)          // own chaos seed
      ) u_lane (
         .wr_clk       (wr_clk),
         .wr_nreset    (wr_nreset),
         .wr_din       (wr_din),       // shared, only one lane writes
         .wr_en        (lane_write[i]),
         .wr_chaosmode (wr_chaosmode),
         .wr_full      (lane_full[i]),
         .rd_clk       (rd_clk),
         .rd_nreset    (rd_nreset),
         .rd_en        (lane_read[i]),
         .rd_dout      (lane_dout[i]),
         .rd_empty     (lane_empty[i])
      );
   end

   //########################################
   // read collection
   //########################################
   lane_merger u_merger
   (
      .rd_clk     (rd_clk),
      .rd_nreset  (rd_nreset),
      .rd_en      (rd_en),
      .lane_empty (lane_empty),
      .lane_dout  (lane_dout),
      .lane_read  (lane_read),
      .rd_dout    (rd_dout),
      .rd_empty   (rd_empty)
   );

endmodule

// ==== tb_clk_gen.sv ====
/* free-running clock, reset held low for RESET_CYCLES then released on a falling edge */
`timescale 1ns/1ps

module tb_clk_gen
#(
   parameter real PERIOD       = 100.0,   // ns
   parameter int  RESET_CYCLES = 5
)
(
   output logic clk,
   output logic nreset
);

   initial
   begin
      clk    = 1'b0;
      nreset = 1'b0;   // asserted from time zero
   end

   always #(PERIOD / 2.0) clk = ~clk;

   initial
   begin
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      nreset = 1'b1;   // away from the active edge
   end

endmodule

// ==== tb_striped_fifo.sv ====
/* runs the cases in fifo_cases.txt from the project root.
   inputs change and outputs are sampled on falling edges of their own clock */
`timescale 1ns/1ps
`include "fifo_config.svh"

module tb_striped_fifo
   import fifo_data_pkg::*;
;

   localparam real RD_PERIOD = 70.0;                     // ns against 100 on the write side
   localparam int  CAP       = `FIFO_LANES * `FIFO_DEPTH;
   localparam int  TIMEOUT   = 200;                      // cycles per wait

   logic       wr_clk, wr_nreset, wr_en, wr_chaosmode, wr_full;
   logic       rd_clk, rd_nreset, rd_en, rd_empty;
   fifo_word_t wr_din, rd_dout;

   fifo_word_t  sb[$];                 // accepted words not yet read
   logic [15:0] wr_lfsr = 16'd55;      // data and write gaps
   logic [15:0] rd_lfsr = 16'd55;      // read gaps
   int          n_err, n_good, n_bad;
   bit          full_early;            // full seen below capacity

   tb_clk_gen #(.PERIOD(100.0))     u_wr_clk (.clk(wr_clk), .nreset(wr_nreset));
   tb_clk_gen #(.PERIOD(RD_PERIOD)) u_rd_clk (.clk(rd_clk), .nreset(rd_nreset));

   striped_async_fifo DUT
   (
      .wr_clk (wr_clk), .wr_nreset (wr_nreset), .wr_din (wr_din), .wr_en (wr_en),
      .wr_chaosmode (wr_chaosmode), .wr_full (wr_full),
      .rd_clk (rd_clk), .rd_nreset (rd_nreset), .rd_en (rd_en),
      .rd_dout (rd_dout), .rd_empty (rd_empty)
   );

   //########################################
   // helpers
   //########################################
   // right-shifting galois step for x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   task automatic take_bits(inout logic [15:0] st, input int n, output int unsigned v);
      v = 0;
      for (int i = 0; i < n; i++)
      begin
         v  = (v << 1) | st[0];   // one step per bit
         st = lfsr_step(st);
      end
   endtask

   task automatic flag_error(input string msg);
      $display("ERROR at %0t: %s", $time, msg);
      n_err++;
   endtask

   task automatic report_timeout(input string what);
      $display("timeout: %s did not happen within %0d cycles", what, TIMEOUT);
      n_err++;
   endtask

   task automatic close_test(input string name, input int err_before);
      if (n_err == err_before)
      begin
         n_good++;
         $display("%s: ok", name);
      end
      else
      begin
         n_bad++;
         $display("%s: failed with %0d errors", name, n_err - err_before);
      end
   endtask

   //########################################
   // write and read sides
   //########################################
   // decides at the falling edge while full holds until the next rising edge
   task automatic write_words(input int n, input int gap);
      int unsigned g, d;
      int          wait_cnt;
      for (int i = 0; i < n; i++)
      begin
         take_bits(wr_lfsr, 3, g);
         repeat (g % (gap + 1))
         begin
            @(negedge wr_clk);
            wr_en = 1'b0;   // idle gap
         end
         take_bits(wr_lfsr, `FIFO_DW, d);
         wait_cnt = 0;
         @(negedge wr_clk);
         while (wr_full && wait_cnt < TIMEOUT)
         begin
            if (sb.size() < CAP)
               full_early = 1'b1;
            wr_en = 1'b0;
            wait_cnt++;
            @(negedge wr_clk);
         end
         if (wr_full)
         begin
            report_timeout("wr_full release");
            break;
         end
         wr_en  = 1'b1;
         wr_din = fifo_word_t'(d);
         sb.push_back(fifo_word_t'(d));   // taken at next rising edge
      end
      @(negedge wr_clk);
      wr_en = 1'b0;
   endtask

   task automatic read_words(input int n, input int gap);
      int unsigned g;
      int          wait_cnt;
      fifo_word_t  expected;
      for (int i = 0; i < n; i++)
      begin
         take_bits(rd_lfsr, 3, g);
         repeat (g % (gap + 1))
         begin
            @(negedge rd_clk);
            rd_en = 1'b0;
         end
         wait_cnt = 0;
         @(negedge rd_clk);
         while (rd_empty && wait_cnt < TIMEOUT)
         begin
            rd_en = 1'b0;
            wait_cnt++;
            @(negedge rd_clk);
         end
         if (rd_empty)
         begin
            report_timeout($sformatf("arrival of word %0d", i));
            break;
         end
         assert (sb.size() > 0) else flag_error("word read that was never written");
         if (sb.size() > 0)
         begin
            expected = sb.pop_front();   // oldest accepted write
            assert (rd_dout == expected)
               else flag_error($sformatf("read %h, expected %h", rd_dout, expected));
         end
         rd_en = 1'b1;
      end
      @(negedge rd_clk);
      rd_en = 1'b0;
   endtask

   //########################################
   // one case from the file
   //########################################
   task automatic run_case(input int id, input string mode, input int words,
                           input int wgap, input int rgap);
      int err_before;
      err_before = n_err;
      full_early = 1'b0;
      sb.delete();
      repeat (6) @(negedge wr_clk);   // pointers settle across domains
      if (mode == "burst")
      begin
         assert (words == CAP) else flag_error($sformatf("burst of %0d words", words));
         write_words(CAP, 0);
         assert (wr_full) else flag_error("wr_full low after last fill write");
         for (int i = 0; i < 8; i++)
         begin
            wr_en  = 1'b1;                  // refused and never stored
            wr_din = fifo_word_t'(~i);
            @(negedge wr_clk);
            assert (wr_full) else flag_error("wr_full dropped with no reads");
         end
         wr_en = 1'b0;
         read_words(CAP, 0);
      end
      else if (mode == "stream" || mode == "chaos")
      begin
         wr_chaosmode = (mode == "chaos");
         fork
            write_words(words, wgap);
            read_words(words, rgap);
         join
         @(negedge wr_clk);                 // back on the write clock
         wr_chaosmode = 1'b0;
         if (mode == "chaos")
            assert (full_early) else flag_error("no wr_full below capacity in chaos mode");
      end
      else
      begin
         $display("case %0d has an unknown mode %s", id, mode);
         n_err++;
      end
      assert (rd_empty) else flag_error("rd_empty low after the last word");
      assert (sb.size() == 0) else flag_error($sformatf("%0d words never read", sb.size()));
      close_test($sformatf("case %0d %s", id, mode), err_before);
   endtask

   //########################################
   // main sequence
   //########################################
   initial
   begin
      int    fd, rc, id, words, wgap, rgap, wait_cnt, err_before;
      string line, mode;
      wr_din       = '0;
      wr_en        = 1'b0;
      wr_chaosmode = 1'b0;
      rd_en        = 1'b0;
      wait_cnt     = 0;
      while (!(wr_nreset && rd_nreset) && wait_cnt < TIMEOUT)
      begin
         @(negedge wr_clk);
         wait_cnt++;
      end
      if (!(wr_nreset && rd_nreset))
         report_timeout("reset release");
      @(negedge wr_clk);
      err_before = n_err;
      assert (!wr_full) else flag_error("wr_full high after reset");
      assert (rd_empty) else flag_error("rd_empty low after reset");
      close_test("reset state", err_before);

      fd = $fopen("fifo_cases.txt", "r");
      if (fd == 0)
      begin
         $display("could not open fifo_cases.txt for reading");
         n_err++;
      end
      else
      begin
         while (!$feof(fd))
         begin
            rc = $fgets(line, fd);
            if (rc > 0 && line[0] != "#")   // skip column notes
               if ($sscanf(line, "%d %s %d %d %d", id, mode, words, wgap, rgap) == 5)
                  run_case(id, mode, words, wgap, rgap);
         end
         $fclose(fd);
      end

      $display("tests passed: %0d, tests failed: %0d", n_good, n_bad);
      if (n_err == 0 && n_bad == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule
